/* include/aui_cfg.svh */
`ifndef AUI_CFG_SVH
`define AUI_CFG_SVH

// Lane structure of the receive interface
`define AUI_LANES         16   // Physical lanes, one marker each per period
`define AUI_AM_WIDTH      120  // Bits in one alignment marker window

// Logical lane numbering
`define AUI_LANE_ID_WIDTH 4    // Enough for 16 logical lanes

// Marker spacing on one lane
// Sync strobes of a lane repeat every AUI_AM_PERIOD cycles
`define AUI_AM_PERIOD     8191

// Gap counter must hold AUI_AM_PERIOD - 1 and saturate above it
`define AUI_GAP_WIDTH     13

`endif

/* rtl/aui_pkg.sv */
`include "aui_cfg.svh"

package aui_pkg;

    typedef logic [`AUI_LANE_ID_WIDTH-1:0] lane_id_t; // Logical lane number

    // Marker bytes MSB first: UM5 UM4 UM3 UP2 UM2 UM1 UM0 UP1 CM5 CM4 CM3 UP0 CM2 CM1 CM0
    typedef struct packed {
        logic [47:0] unique_hi; // UM5 UM4 UM3 UP2 UM2 UM1
        logic [15:0] tail;      // UM0 UP1, last lane-specific pair
        logic [23:0] common_a;  // CM5 CM4 CM3
        logic [7:0]  lane_byte; // UP0
        logic [23:0] common_b;  // CM2 CM1 CM0
    } am_fields_t;

    // Same 120 bits, raw for capture and split for matching
    typedef union packed {
        logic [`AUI_AM_WIDTH-1:0] raw;
        am_fields_t               fld;
    } am_word_u;

    localparam logic [23:0] AM_COMMON_A = 24'hD9B565; // Identical on every lane
    localparam logic [23:0] AM_COMMON_B = 24'h264A9A;

    // Expected markers, bit order as received, index is the logical lane
    localparam am_word_u AM_TABLE [`AUI_LANES] = '{
        120'hF37101260C8EFED9D9B565B6264A9A, 120'h7EDE5A988121A567D9B56504264A9A,
        120'h56F33E01A90CC1FED9B56546264A9A, 120'hD080867B2F7F7984D9B5655A264A9A,
        120'hF2512AE60DAED519D9B565E1264A9A, 120'hD14F12B12EB0ED4ED9B565F2264A9A,
        120'hA19C42115E63BDEED9B5653D264A9A, 120'h5B76D6CDA4892932D9B56522264A9A,
        120'h7573E1608A8C1E9FD9B56560264A9A, 120'h3CC4715DC33B8EA2D9B5656B264A9A,
        120'hD8EB95FB27146A04D9B565FA264A9A, 120'h3866228EC799DD71D9B5656C264A9A,
        120'h95F6A2A46A095D5BD9B56518264A9A, 120'hC39731333C68CECCD9B56514264A9A,
        120'hA6FBCA4E590435B1D9B565D0264A9A, 120'h79BAA6A986455956D9B565B4264A9A
    };

endpackage

/* rtl/am_capture.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

// Stage 1: register strobes and marker windows of all lanes
module am_capture import aui_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  am_word_u              i_am [`AUI_LANES], // Marker window per lane
    input  logic [`AUI_LANES-1:0] i_sync,            // High when window holds a marker
    output am_word_u              o_am_q [`AUI_LANES],
    output logic [`AUI_LANES-1:0] o_sync_q
);

    // Strobes are control, cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sync_q <= '0;
        end else begin
            o_sync_q <= i_sync;
        end
    end

    // Marker payload
    // A lane without sync loads zero so nothing stale reaches the matcher
    always_ff @(posedge clk) begin
        for (int k = 0; k < `AUI_LANES; k++) begin
            if (i_sync[k]) begin
                o_am_q[k].raw <= i_am[k].raw; // Raw view, fields split later
            end else begin
                o_am_q[k].raw <= '0;
            end
        end
    end

    // Zero word never matches, common fields differ from the constants
    // so a missing sync cannot produce a hit downstream

endmodule

/* rtl/am_match.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

// Stage 2: decode each captured marker against the expected table
module am_match import aui_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  am_word_u              i_am_q [`AUI_LANES], // Captured marker per lane
    input  logic [`AUI_LANES-1:0] i_sync_q,
    output logic [`AUI_LANES-1:0] o_sync_m,            // Strobe delayed to match o_hit
    output logic [`AUI_LANES-1:0] o_hit,               // Marker equals some table entry
    output lane_id_t              o_id [`AUI_LANES]    // Index of the matching entry
);

    logic [`AUI_LANES-1:0] common_ok; // Fixed fields correct on this lane
    logic [`AUI_LANES-1:0] hit_c;
    lane_id_t              id_c [`AUI_LANES];

    // Field-wise compare through the union
    always_comb begin
        for (int k = 0; k < `AUI_LANES; k++) begin
            common_ok[k] = (i_am_q[k].fld.common_a == AM_COMMON_A) &&
                           (i_am_q[k].fld.common_b == AM_COMMON_B);
            hit_c[k] = 1'b0;
            id_c[k]  = '0;
            // Only unique fields need checking once the common ones agree
            for (int j = 0; j < `AUI_LANES; j++) begin
                if (common_ok[k] &&
                    i_am_q[k].fld.unique_hi == AM_TABLE[j].fld.unique_hi &&
                    i_am_q[k].fld.tail      == AM_TABLE[j].fld.tail &&
                    i_am_q[k].fld.lane_byte == AM_TABLE[j].fld.lane_byte) begin
                    hit_c[k] = 1'b1;
                    id_c[k]  = lane_id_t'(j); // Table entries are distinct, at most one hit
                end
            end
        end
    end

    // Strobe and hit flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sync_m <= '0;
            o_hit    <= '0;
        end else begin
            o_sync_m <= i_sync_q;
            o_hit    <= hit_c;
        end
    end

    // Lane index travels with the hit, only read while o_sync_m is high
    always_ff @(posedge clk) begin
        for (int k = 0; k < `AUI_LANES; k++) begin
            o_id[k] <= id_c[k];
        end
    end

endmodule

/* rtl/lane_lock.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

// Stage 3: per-lane gap timing, lane repeat check and lock decision
module lane_lock import aui_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_sync_m,   // Marker present this cycle
    input  logic     i_hit,      // Marker found in the table
    input  lane_id_t i_id,       // Logical lane carried by the marker
    output logic     o_locked,
    output lane_id_t o_lane_id,  // Logical lane stored at the first marker
    output logic     o_am_error, // Sticky, bad or changing marker
    output logic     o_gap_error // Sticky, marker spacing off
);

    // Count seen at a sync when markers are exactly one period apart
    localparam logic [`AUI_GAP_WIDTH-1:0] GAP_TARGET = `AUI_GAP_WIDTH'(`AUI_AM_PERIOD - 1);

    logic [`AUI_GAP_WIDTH-1:0] gap_cnt;    // Cycles since the last sync
    logic                      has_synced; // At least one marker seen
    logic                      gap_ok;
    logic                      id_same;
    logic                      am_bad;     // Error condition at this sync
    logic                      gap_bad;
    logic                      lock_ok;    // Later marker with nothing wrong

    assign gap_ok  = (gap_cnt == GAP_TARGET);
    assign id_same = (i_id == o_lane_id);

    // Miss counts on any marker, lane change only after the first
    assign am_bad  = i_sync_m && (!i_hit || (has_synced && !id_same));
    assign gap_bad = i_sync_m && has_synced && !gap_ok;

    assign lock_ok = i_sync_m && has_synced && i_hit && id_same && gap_ok &&
                     !o_am_error && !o_gap_error;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gap_cnt     <= '0;
            has_synced  <= 1'b0;
            o_lane_id   <= '0;
            o_locked    <= 1'b0;
            o_am_error  <= 1'b0;
            o_gap_error <= 1'b0;
        end else begin
            // Gap counter restarts on every marker
            if (i_sync_m) begin
                gap_cnt <= '0;
            end else if (gap_cnt != '1) begin
                gap_cnt <= gap_cnt + 1'b1; // Saturate so a long silence never wraps to a good gap
            end

            if (i_sync_m && !has_synced) begin
                has_synced <= 1'b1;
                o_lane_id  <= i_id; // Mapping taken from the first marker
            end

            // Sticky error flags
            if (am_bad) begin
                o_am_error <= 1'b1;
            end
            if (gap_bad) begin
                o_gap_error <= 1'b1;
            end

            // Lock follows the error state, never set while a flag is up
            if (am_bad || gap_bad) begin
                o_locked <= 1'b0;
            end else if (lock_ok) begin
                o_locked <= 1'b1;
            end
        end
    end

endmodule

/* rtl/aui_checker.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

// Alignment marker checker, capture -> match -> per-lane lock
module aui_checker import aui_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  am_word_u              i_am [`AUI_LANES], // Marker windows from the lanes
    input  logic [`AUI_LANES-1:0] i_sync,            // Marker strobes
    output logic [`AUI_LANES-1:0] o_lane_locked,
    output lane_id_t              o_lane_id [`AUI_LANES], // Recovered logical lane
    output logic [`AUI_LANES-1:0] o_am_error,
    output logic [`AUI_LANES-1:0] o_gap_error
);

    am_word_u              am_q [`AUI_LANES]; // Capture -> match
    logic [`AUI_LANES-1:0] sync_q;
    logic [`AUI_LANES-1:0] sync_m;            // Match -> lane_lock
    logic [`AUI_LANES-1:0] hit;
    lane_id_t              id_m [`AUI_LANES];

    am_capture u_capture (
        .clk      (clk),
        .rst      (rst),
        .i_am     (i_am),
        .i_sync   (i_sync),
        .o_am_q   (am_q),
        .o_sync_q (sync_q)
    );

    am_match u_match (
        .clk      (clk),
        .rst      (rst),
        .i_am_q   (am_q),
        .i_sync_q (sync_q),
        .o_sync_m (sync_m),
        .o_hit    (hit),
        .o_id     (id_m)
    );

    // One lock tracker per physical lane
    for (genvar k = 0; k < `AUI_LANES; k++) begin : g_lane
        lane_lock u_lock (
            .clk         (clk),
            .rst         (rst),
            .i_sync_m    (sync_m[k]),
            .i_hit       (hit[k]),
            .i_id        (id_m[k]),
            .o_locked    (o_lane_locked[k]),
            .o_lane_id   (o_lane_id[k]),
            .o_am_error  (o_am_error[k]),
            .o_gap_error (o_gap_error[k])
        );
    end

endmodule

/* sim/aui_checker_sva.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

// Protocol properties of the checker outputs, bound to the top level
module aui_checker_sva import aui_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [`AUI_LANES-1:0] i_sync,        // Raw marker strobes at the DUT input
    input logic [`AUI_LANES-1:0] i_lane_locked,
    input lane_id_t              i_lane_id [`AUI_LANES],
    input logic [`AUI_LANES-1:0] i_am_error,
    input logic [`AUI_LANES-1:0] i_gap_error
);

    for (genvar k = 0; k < `AUI_LANES; k++) begin : g_lane
        // All outputs cleared while reset is held
        a_reset_zero: assert property (@(posedge clk) rst |->
            (!i_lane_locked[k] && !i_am_error[k] && !i_gap_error[k] && i_lane_id[k] == '0))
            else $error("lane %0d output not zero during reset", k);

        // First clocked update after release keeps the reset values
        a_release_zero: assert property (@(posedge clk) $fell(rst) |=>
            (!i_lane_locked[k] && !i_am_error[k] && !i_gap_error[k] && i_lane_id[k] == '0))
            else $error("lane %0d output not zero right after reset", k);

        a_am_sticky: assert property (@(posedge clk) disable iff (rst)
            i_am_error[k] |=> i_am_error[k]) // Flag only clears on reset
            else $error("lane %0d marker error flag dropped", k);

        a_gap_sticky: assert property (@(posedge clk) disable iff (rst)
            i_gap_error[k] |=> i_gap_error[k])
            else $error("lane %0d gap error flag dropped", k);

        // Lock and any error flag are mutually exclusive
        a_lock_clean: assert property (@(posedge clk) disable iff (rst)
            i_lane_locked[k] |-> !(i_am_error[k] || i_gap_error[k]))
            else $error("lane %0d locked with an error flag set", k);

        // Three register stages from strobe to lock
        a_lock_latency: assert property (@(posedge clk) disable iff (rst)
            $rose(i_lane_locked[k]) |-> $past(i_sync[k], 3))
            else $error("lane %0d lock rose without a sync three cycles earlier", k);
    end

endmodule

/* sim/aui_checker_tb.sv */
`timescale 1ns/100ps
`include "aui_cfg.svh"

module aui_checker_tb import aui_pkg::*; ();

    localparam int WAIT_LIMIT = 20;                  // Cycles allowed for outputs to settle
    localparam int SYNC_LIMIT = `AUI_AM_PERIOD + 10; // Longest idle stretch between rounds

    logic                  clk;
    logic                  rst;
    am_word_u              i_am [`AUI_LANES];
    logic [`AUI_LANES-1:0] i_sync;
    logic [`AUI_LANES-1:0] o_lane_locked;
    lane_id_t              o_lane_id [`AUI_LANES];
    logic [`AUI_LANES-1:0] o_am_error;
    logic [`AUI_LANES-1:0] o_gap_error;

    int          perm [`AUI_LANES]; // Logical lane carried by each physical lane
    logic [31:0] rng_state;
    int          cyc = 0;           // Rising edges since time zero
    int          round_cyc;         // Edge count when the last round was driven
    int          errors = 0;
    int          test_errors = 0;   // Error count at the start of the current test
    int          tests_run = 0;
    int          tests_failed = 0;

    aui_checker i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_am          (i_am),
        .i_sync        (i_sync),
        .o_lane_locked (o_lane_locked),
        .o_lane_id     (o_lane_id),
        .o_am_error    (o_am_error),
        .o_gap_error   (o_gap_error)
    );

    bind aui_checker aui_checker_sva u_sva (
        .clk           (clk),
        .rst           (rst),
        .i_sync        (i_sync),
        .i_lane_locked (o_lane_locked),
        .i_lane_id     (o_lane_id),
        .i_am_error    (o_am_error),
        .i_gap_error   (o_gap_error)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst    = 1'b1;
        i_sync = '0;
        repeat (5) step();
        rst = 1'b0;
    endtask

    // Fisher-Yates shuffle of logical lanes over physical lanes
    task automatic shuffle_lanes();
        int j;
        int t;
        for (int k = 0; k < `AUI_LANES; k++) perm[k] = k;
        for (int k = `AUI_LANES - 1; k > 0; k--) begin
            rng_state = xorshift(rng_state);
            j         = int'(rng_state % 32'(k + 1));
            t         = perm[k];
            perm[k]   = perm[j];
            perm[j]   = t;
        end
    endtask

    // One marker round; kind 1 flips a common bit, kind 2 sends the next table entry
    task automatic send_round(input logic [`AUI_LANES-1:0] lanes, input int bad_lane,
                              input int bad_kind);
        for (int k = 0; k < `AUI_LANES; k++) begin
            i_am[k] = AM_TABLE[perm[k]];
            if (k == bad_lane && bad_kind == 1) begin
                i_am[k].fld.common_a[0] = ~i_am[k].fld.common_a[0];
            end else if (k == bad_lane && bad_kind == 2) begin
                i_am[k] = AM_TABLE[(perm[k] + 1) % `AUI_LANES]; // Valid but foreign lane
            end
        end
        i_sync    = lanes;
        round_cyc = cyc;
        step();
        i_sync = '0; // Strobe lasts one cycle
    endtask

    task automatic wait_cycle(input int target);
        int guard;
        guard = 0;
        while (cyc < target && guard < SYNC_LIMIT) begin
            step();
            guard++;
        end
        if (cyc < target) begin
            $display("Timeout: cycle %0d was never reached", target);
            errors++;
        end
    endtask

    // 0 lock, 1 marker error, 2 gap error
    function automatic logic [`AUI_LANES-1:0] pick(input int sel);
        case (sel)
            0:       return o_lane_locked;
            1:       return o_am_error;
            default: return o_gap_error;
        endcase
    endfunction

    task automatic wait_vec(input int sel, input logic [`AUI_LANES-1:0] want, input string what);
        int guard;
        guard = 0;
        while (pick(sel) !== want && guard < WAIT_LIMIT) begin
            step();
            guard++;
        end
        if (pick(sel) !== want) begin
            $display("Timeout: %s never reached %h, it stayed at %h", what, want, pick(sel));
            errors++;
        end
    endtask

    task automatic check_vec(input int sel, input logic [`AUI_LANES-1:0] want, input string what);
        assert (pick(sel) === want) else begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, pick(sel), want);
            errors++;
        end
    endtask

    // Recovered lane numbers, zero after reset or the shuffled mapping
    task automatic check_ids(input logic mapped);
        lane_id_t want;
        for (int k = 0; k < `AUI_LANES; k++) begin
            want = mapped ? lane_id_t'(perm[k]) : '0;
            assert (o_lane_id[k] === want) else begin
                $display("ERROR %0t: o_lane_id[%0d] is %0d, expected %0d",
                         $time, k, o_lane_id[k], want);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        int first_cyc;
        rst    = 1'b1;
        i_sync = '0;
        for (int k = 0; k < `AUI_LANES; k++) i_am[k] = '0;
        rng_state = 32'h3d983238;
        shuffle_lanes();
        apply_reset();

        wait_cycle(cyc + 20); // Idle, nothing may move
        check_vec(0, '0, "o_lane_locked");
        check_vec(1, '0, "o_am_error");
        check_vec(2, '0, "o_gap_error");
        check_ids(1'b0);
        finish_test("reset state");

        send_round('1, -1, 0);
        wait_cycle(round_cyc + `AUI_AM_PERIOD);
        send_round('1, -1, 0);
        wait_vec(0, '1, "o_lane_locked");
        check_vec(1, '0, "o_am_error");
        check_vec(2, '0, "o_gap_error");
        check_ids(1'b1);
        finish_test("lock and lane mapping");

        apply_reset();
        send_round('1, 3, 1);
        wait_vec(1, 16'h0008, "o_am_error");
        wait_cycle(round_cyc + `AUI_AM_PERIOD);
        send_round('1, -1, 0);
        wait_vec(0, 16'hfff7, "o_lane_locked"); // Lane 3 stays out
        check_vec(1, 16'h0008, "o_am_error");
        check_vec(2, '0, "o_gap_error");
        finish_test("corrupt marker");

        apply_reset();
        send_round('1, -1, 0);
        wait_cycle(round_cyc + `AUI_AM_PERIOD);
        send_round('1, 5, 2);
        wait_vec(0, 16'hffdf, "o_lane_locked");
        check_vec(1, 16'h0020, "o_am_error");
        check_vec(2, '0, "o_gap_error");
        finish_test("lane change");

        apply_reset();
        send_round('1, -1, 0);
        first_cyc = round_cyc;
        wait_cycle(first_cyc + `AUI_AM_PERIOD - 100);
        send_round(16'h0080, -1, 0); // Lane 7 only, too early
        wait_vec(2, 16'h0080, "o_gap_error");
        wait_cycle(first_cyc + `AUI_AM_PERIOD);
        send_round('1, -1, 0);
        wait_vec(0, 16'hff7f, "o_lane_locked");
        check_vec(2, 16'h0080, "o_gap_error");
        check_vec(1, '0, "o_am_error");
        finish_test("wrong gap");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* aui_checker.f */
+incdir+include
rtl/aui_pkg.sv
rtl/am_capture.sv
rtl/am_match.sv
rtl/lane_lock.sv
rtl/aui_checker.sv
sim/aui_checker_sva.sv
sim/aui_checker_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aui_checker_tb \
    -f aui_checker.f -o aui_checker_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/aui_checker_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log && exit 0 || exit 1
